/* filelist.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/word_fifo.sv
verilog/block_ram.sv
verilog/mem_arbiter.sv
verilog/host_cmd_ctrl.sv
verilog/cpu_bus_decoder.sv
verilog/small_soc_top.sv
test/tb_checker.sv
test/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_top -o tb_top_sim \
   > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

grep -qx "sim passed" sim.log && exit 0 || exit 1

/* test/tb_checker.sv */
// testbench checker with model memory, uart queues, reference functions and compares
`include "soc_defs.svh"

module tb_checker import soc_pkg::*; (
   input  logic  clk100mhz,
   input  logic  cpu_reset,
   input  word_t host_data,
   input  logic  host_ack,
   input  logic  reply_req,
   input  word_t reply_data,
   input  addr_t cpu_addr,
   input  word_t cpu_wdata,
   input  word_t cpu_rdata,
   input  logic  cpu_rdata_ready,
   input  logic  cpu_wr_ack,
   input  logic  cpu_hold,
   input  int    test_num,
   input  logic  test_end,
   input  logic  run_done,
   output int    err_count
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum {M_IDLE, M_BOOT_COUNT, M_BOOT_DATA, M_MEMRD, M_SEND} model_state_t;

   word_t        model_mem [`RAM_DEPTH];
   word_t        in_q [$];      // host to cpu
   word_t        out_q [$];     // cpu to host
   word_t        exp_reply [$];
   logic         exp_hold [$];  // cpu_hold expected with each reply
   model_state_t mstate;
   word_t        boot_left;
   ram_addr_t    boot_addr;
   logic         model_hold;
   logic         rst_q;
   logic         host_ack_q;
   logic         reply_req_q;
   logic         rdata_ready_q;
   logic         wr_ack_q;
   logic         done_q;
   int           errors = 0;
   int           checks = 0;
   int           test_errs = 0;
   int           tests_ok = 0;
   int           tests_bad = 0;

   assign err_count = errors;

   // head of the outbound fifo, or the empty marker
   function automatic word_t ref_poll();
      return (out_q.size() > 0) ? out_q[0] : `POLL_EMPTY;
   endfunction

   function automatic word_t ref_cpu_read(addr_t a);
      if (a >= `MEM_BASE)
         return model_mem[ram_addr_t'(a - `MEM_BASE)];
      case (a)
         `REG_UART_IN:  return (in_q.size() > 0) ? in_q[0] : '0;
         `REG_IN_STAT:  return word_t'(in_q.size() > 0);
         `REG_OUT_STAT: return word_t'(out_q.size() < `FIFO_DEPTH);
         default:       return '0; // unmapped
      endcase
   endfunction

   function automatic string test_name(int n);
      case (n)
         1:       return "reset state";
         2:       return "bootload";
         3:       return "cpu memory window";
         4:       return "inbound uart";
         5:       return "outbound uart";
         default: return "unnamed";
      endcase
   endfunction

   task automatic compare(input string sig, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("Error: %s is %h, expected %h", sig, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      errors++;
      test_errs++;
   endtask

   task automatic expect_reply(input word_t w);
      exp_reply.push_back(w);
      exp_hold.push_back(model_hold);
   endtask

   // follows the host command stream word by word
   task automatic take_host_word(input word_t w);
      case (mstate)
         M_IDLE: begin
            case (w[15:0])
               `CMD_BOOT:  mstate = M_BOOT_COUNT;
               `CMD_MEMRD: mstate = M_MEMRD;
               `CMD_SEND:  mstate = M_SEND;
               `CMD_POLL: begin
                  expect_reply(ref_poll());
                  if (out_q.size() > 0)
                     void'(out_q.pop_front());
               end
               default: mstate = M_IDLE;
            endcase
         end
         M_BOOT_COUNT: begin
            boot_left = w;
            boot_addr = '0;
            mstate    = (w == '0) ? M_IDLE : M_BOOT_DATA;
         end
         M_BOOT_DATA: begin
            model_mem[boot_addr] = w;
            boot_left--;
            if (boot_left == '0) begin
               model_hold = 1'b0; // released with the last echo
               mstate     = M_IDLE;
            end
            expect_reply(model_mem[boot_addr]);
            boot_addr++;
         end
         M_MEMRD: begin
            expect_reply(model_mem[w[`RAM_AW-1:0]]);
            mstate = M_IDLE;
         end
         M_SEND: begin
            if (in_q.size() < `FIFO_DEPTH)
               in_q.push_back(w);
            mstate = M_IDLE;
         end
         default: mstate = M_IDLE;
      endcase
   endtask

   task automatic check_reply();
      if (exp_reply.size() == 0) begin
         report_failure($sformatf("reply %h arrived with no request outstanding", reply_data));
      end else begin
         compare("reply_data", reply_data, exp_reply.pop_front());
         compare("cpu_hold", word_t'(cpu_hold), word_t'(exp_hold.pop_front()));
      end
   endtask

   task automatic report_test(input int n);
      if (test_errs == 0) begin
         tests_ok++;
         $display("test %0d %s: ok", n, test_name(n));
      end else begin
         tests_bad++;
         $display("test %0d %s: %0d errors", n, test_name(n), test_errs);
      end
      test_errs = 0;
   endtask

   always @(posedge clk100mhz) begin
      rst_q         <= cpu_reset;
      host_ack_q    <= host_ack;
      reply_req_q   <= reply_req;
      rdata_ready_q <= cpu_rdata_ready;
      wr_ack_q      <= cpu_wr_ack;
      done_q        <= run_done;
      if (!cpu_reset) begin
         mstate     = M_IDLE;
         model_hold = 1'b1;
         in_q.delete();
         out_q.delete();
         exp_reply.delete();
         exp_hold.delete();
      end else begin
         if (!rst_q) begin // first cycle out of reset
            compare("host_ack", word_t'(host_ack), '0);
            compare("reply_req", word_t'(reply_req), '0);
            compare("cpu_rdata_ready", word_t'(cpu_rdata_ready), '0);
            compare("cpu_wr_ack", word_t'(cpu_wr_ack), '0);
            compare("cpu_hold", word_t'(cpu_hold), 32'h1);
         end
         if (host_ack && !host_ack_q)
            take_host_word(host_data);
         if (reply_req && !reply_req_q)
            check_reply();
         if (cpu_rdata_ready && !rdata_ready_q) begin
            compare("cpu_rdata", cpu_rdata, ref_cpu_read(cpu_addr));
            if (cpu_addr == `REG_UART_IN && in_q.size() > 0)
               void'(in_q.pop_front());
         end
         if (cpu_wr_ack && !wr_ack_q) begin
            if (cpu_addr >= `MEM_BASE)
               model_mem[ram_addr_t'(cpu_addr - `MEM_BASE)] = cpu_wdata;
            else if (cpu_addr == `REG_UART_OUT && out_q.size() < `FIFO_DEPTH)
               out_q.push_back(cpu_wdata);
         end
      end
      if (test_end)
         report_test(test_num);
      if (run_done && !done_q) begin
         if (exp_reply.size() > 0)
            report_failure($sformatf("%0d expected replies never arrived", exp_reply.size()));
         $display("tests: %0d ok, %0d failed, %0d checks, %0d errors",
                  tests_ok, tests_bad, checks, errors);
      end
   end

endmodule

/* test/tb_top.sv */
// testbench top with clock, reset, dut, host and cpu bus stimulus, timeout
`include "soc_defs.svh"

module tb_top import soc_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BOOT_LEN = 16;
   localparam int WORDS_MOVED = (2 + 2 * BOOT_LEN)      // bootload words and echoes
      + (BOOT_LEN + 4)                                   // cpu window and host read
      + 6                                                // inbound uart
      + (2 * `FIFO_DEPTH + 1) + 2 * (`FIFO_DEPTH + 1);   // outbound uart and polls
   localparam int CYCLE_LIMIT = 200 * WORDS_MOVED + 2000;

   logic  clk100mhz;
   logic  cpu_reset;
   logic  host_req;
   word_t host_data;
   logic  host_ack;
   logic  reply_req;
   word_t reply_data;
   logic  reply_ack;
   logic  cpu_rd;
   logic  cpu_wr;
   addr_t cpu_addr;
   word_t cpu_wdata;
   word_t cpu_rdata;
   logic  cpu_rdata_ready;
   logic  cpu_wr_ack;
   logic  cpu_hold;
   int    test_num;
   logic  test_end;
   logic  run_done;
   int    err_count;
   int    seed = 55;
   int    cycles = 0;

   small_soc_top small_soc_top_inst (.*);

   tb_checker scoreboard (.*);

   initial begin
      clk100mhz = 1'b0;
      forever #5 clk100mhz = ~clk100mhz;
   end

   always @(posedge clk100mhz) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run stopped by timeout after %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // one word on the host channel, held until host_ack
   task automatic send_word(input word_t w);
      @(posedge clk100mhz);
      host_req  <= 1'b1;
      host_data <= w;
      @(posedge clk100mhz);
      while (!host_ack) @(posedge clk100mhz);
      host_req <= 1'b0;
      @(posedge clk100mhz);
      while (host_ack) @(posedge clk100mhz);
   endtask

   task automatic send_cmd(input logic [15:0] code);
      send_word({16'h0000, code});
   endtask

   task automatic take_reply();
      @(posedge clk100mhz);
      while (!reply_req) @(posedge clk100mhz);
      reply_ack <= 1'b1;
      @(posedge clk100mhz);
      while (reply_req) @(posedge clk100mhz);
      reply_ack <= 1'b0;
   endtask

   task automatic cpu_read(input addr_t a);
      @(posedge clk100mhz);
      cpu_rd   <= 1'b1;
      cpu_addr <= a;
      @(posedge clk100mhz);
      while (!cpu_rdata_ready) @(posedge clk100mhz);
      cpu_rd <= 1'b0;
      @(posedge clk100mhz);
      while (cpu_rdata_ready) @(posedge clk100mhz);
   endtask

   task automatic cpu_write(input addr_t a, input word_t d);
      @(posedge clk100mhz);
      cpu_wr    <= 1'b1;
      cpu_addr  <= a;
      cpu_wdata <= d;
      @(posedge clk100mhz);
      while (!cpu_wr_ack) @(posedge clk100mhz);
      cpu_wr <= 1'b0;
      @(posedge clk100mhz);
      while (cpu_wr_ack) @(posedge clk100mhz);
   endtask

   task automatic end_test(input int n);
      @(posedge clk100mhz);
      test_num <= n;
      test_end <= 1'b1;
      @(posedge clk100mhz);
      test_end <= 1'b0;
   endtask

   task automatic run_bootload();
      send_cmd(`CMD_BOOT);
      send_word(BOOT_LEN);
      for (int i = 0; i < BOOT_LEN; i++) begin
         send_word($random(seed));
         take_reply();
      end
   endtask

   task automatic run_cpu_window();
      for (int i = 0; i < BOOT_LEN; i++)
         cpu_read(`MEM_BASE + i);
      cpu_write(`MEM_BASE + 100, $random(seed));
      send_cmd(`CMD_MEMRD);
      send_word(100); // same word, seen from the host side
      take_reply();
   endtask

   task automatic run_uart_in();
      send_cmd(`CMD_SEND);
      send_word($random(seed));
      cpu_read(`REG_IN_STAT);
      cpu_read(`REG_UART_IN);
      cpu_read(`REG_IN_STAT);
      cpu_read(32'h0001_0003); // unmapped register
   endtask

   task automatic run_uart_out();
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         cpu_read(`REG_OUT_STAT);
         cpu_write(`REG_UART_OUT, $random(seed));
      end
      cpu_read(`REG_OUT_STAT);
      // one poll more than words written
      for (int i = 0; i <= `FIFO_DEPTH; i++) begin
         send_cmd(`CMD_POLL);
         take_reply();
      end
   endtask

   initial begin
      cpu_reset = 1'b0;
      host_req  = 1'b0;
      host_data = '0;
      reply_ack = 1'b0;
      cpu_rd    = 1'b0;
      cpu_wr    = 1'b0;
      cpu_addr  = '0;
      cpu_wdata = '0;
      test_num  = 0;
      test_end  = 1'b0;
      run_done  = 1'b0;
      repeat (2) @(posedge clk100mhz);
      cpu_reset <= 1'b1;
      repeat (2) @(posedge clk100mhz);
      end_test(1);
      run_bootload();
      end_test(2);
      run_cpu_window();
      end_test(3);
      run_uart_in();
      end_test(4);
      run_uart_out();
      end_test(5);
      @(posedge clk100mhz);
      run_done <= 1'b1;
      repeat (3) @(posedge clk100mhz);
      if (err_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* verilog/block_ram.sv */
// single-port word ram with registered read
`include "soc_defs.svh"

module block_ram import soc_pkg::*; (
   input  logic      clk100mhz,
   input  logic      we,
   input  ram_addr_t addr,
   input  word_t     wdata,
   output word_t     rdata
);

   word_t mem [`RAM_DEPTH];

   // read returns the old word on a write cycle
   always_ff @(posedge clk100mhz) begin
      if (we)
         mem[addr] <= wdata;
      rdata <= mem[addr];
   end

endmodule

/* verilog/cpu_bus_decoder.sv */
// cpu bus decode into memory requests and uart fifo registers
`include "soc_defs.svh"

module cpu_bus_decoder import soc_pkg::*; (
   input  logic      clk100mhz,
   input  logic      cpu_reset,
   input  logic      cpu_rd,
   input  logic      cpu_wr,
   input  addr_t     cpu_addr,
   input  word_t     cpu_wdata,
   output word_t     cpu_rdata,
   output logic      cpu_rdata_ready,
   output logic      cpu_wr_ack,
   input  logic      cpu_hold,
   mem_bus_if.master mem,
   output logic      in_rd,
   input  word_t     in_rdata,
   input  logic      in_empty,
   output logic      out_wr,
   output word_t     out_wdata,
   input  logic      out_full
);

   cpu_state_t state;
   logic       is_mem;
   logic       rd_wait; // uart in empty
   logic       wr_wait; // uart out full

   assign is_mem  = cpu_addr >= `MEM_BASE;
   assign rd_wait = (cpu_addr == `REG_UART_IN) && in_empty;
   assign wr_wait = (cpu_addr == `REG_UART_OUT) && out_full;

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         state           <= C_IDLE;
         cpu_rdata_ready <= 1'b0;
         cpu_wr_ack      <= 1'b0;
         mem.req         <= 1'b0;
         mem.we          <= 1'b0;
         in_rd           <= 1'b0;
         out_wr          <= 1'b0;
      end else begin
         in_rd  <= 1'b0;
         out_wr <= 1'b0;
         case (state)
            C_IDLE: begin
               if (cpu_hold) begin
                  state <= C_IDLE; // bootload in progress
               end else if (is_mem && (cpu_rd || cpu_wr)) begin
                  mem.addr  <= ram_addr_t'(cpu_addr - `MEM_BASE);
                  mem.we    <= cpu_wr;
                  mem.wdata <= cpu_wdata;
                  state     <= C_MEM;
               end else if (cpu_rd && !rd_wait) begin
                  case (cpu_addr)
                     `REG_UART_IN:  cpu_rdata <= in_rdata;
                     `REG_IN_STAT:  cpu_rdata <= word_t'(!in_empty);
                     `REG_OUT_STAT: cpu_rdata <= word_t'(!out_full);
                     default:       cpu_rdata <= '0;
                  endcase
                  in_rd           <= cpu_addr == `REG_UART_IN;
                  cpu_rdata_ready <= 1'b1;
                  state           <= C_DONE;
               end else if (cpu_wr && !wr_wait) begin
                  out_wr     <= cpu_addr == `REG_UART_OUT; // others ignored
                  out_wdata  <= cpu_wdata;
                  cpu_wr_ack <= 1'b1;
                  state      <= C_DONE;
               end
            end
            C_MEM: begin
               if (!mem.req && !mem.ack) begin
                  mem.req <= 1'b1;
               end else if (mem.req && mem.ack) begin
                  mem.req <= 1'b0;
                  if (mem.we) begin
                     cpu_wr_ack <= 1'b1;
                  end else begin
                     cpu_rdata       <= mem.rdata;
                     cpu_rdata_ready <= 1'b1;
                  end
                  state <= C_DONE;
               end
            end
            C_DONE: begin
               if (!cpu_rd && !cpu_wr) begin
                  cpu_rdata_ready <= 1'b0;
                  cpu_wr_ack      <= 1'b0;
                  state           <= C_IDLE;
               end
            end
            default: state <= C_IDLE;
         endcase
      end
   end

   a_one_reply: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      !(cpu_rdata_ready && cpu_wr_ack));

endmodule

/* verilog/host_cmd_ctrl.sv */
// host command fsm for bootload, memory read, uart send and uart poll
`include "soc_defs.svh"

module host_cmd_ctrl import soc_pkg::*; (
   input  logic      clk100mhz,
   input  logic      cpu_reset,
   input  logic      host_req,
   input  word_t     host_data,
   output logic      host_ack,
   output logic      reply_req,
   output word_t     reply_data,
   input  logic      reply_ack,
   mem_bus_if.master mem,
   output logic      in_wr,
   output word_t     in_wdata,
   input  logic      in_full,
   output logic      out_rd,
   input  word_t     out_rdata,
   input  logic      out_empty,
   output logic      cpu_hold
);

   host_state_t state;
   word_t       boot_count; // words still to load
   logic        wants_word;
   logic        take;
   logic        mem_start;
   logic        mem_done;

   always_comb begin
      case (state)
         H_IDLE, H_BOOT_COUNT, H_BOOT_DATA, H_MEMRD_ADDR, H_SEND_DATA:
            wants_word = 1'b1;
         default:
            wants_word = 1'b0;
      endcase
   end

   // no new word while a reply is still in flight
   assign take = wants_word && host_req && !host_ack && !reply_req && !reply_ack;

   assign mem_start = !mem.req && !mem.ack; // previous ack gone
   assign mem_done  = mem.req && mem.ack;

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         state      <= H_IDLE;
         host_ack   <= 1'b0;
         reply_req  <= 1'b0;
         mem.req    <= 1'b0;
         mem.we     <= 1'b0;
         in_wr      <= 1'b0;
         out_rd     <= 1'b0;
         cpu_hold   <= 1'b1;   // cpu waits for the first bootload
         boot_count <= '0;
      end else begin
         in_wr  <= 1'b0;
         out_rd <= 1'b0;

         if (take)
            host_ack <= 1'b1;
         else if (!host_req)
            host_ack <= 1'b0;

         if (reply_req && reply_ack)
            reply_req <= 1'b0;

         case (state)
            H_IDLE: begin
               if (take) begin
                  case (host_data[15:0])
                     `CMD_BOOT:  state <= H_BOOT_COUNT;
                     `CMD_MEMRD: state <= H_MEMRD_ADDR;
                     `CMD_SEND:  state <= H_SEND_DATA;
                     `CMD_POLL:  state <= H_POLL;
                     default:    state <= H_IDLE; // unknown, dropped
                  endcase
               end
            end
            H_BOOT_COUNT: begin
               if (take) begin
                  boot_count <= host_data;
                  mem.addr   <= '0;
                  cpu_hold   <= host_data != '0;
                  state      <= (host_data == '0) ? H_IDLE : H_BOOT_DATA;
               end
            end
            H_BOOT_DATA: begin
               if (take) begin
                  mem.wdata <= host_data;
                  state     <= H_BOOT_WR;
               end
            end
            H_BOOT_WR: begin
               if (mem_start) begin
                  mem.req <= 1'b1;
                  mem.we  <= 1'b1;
               end else if (mem_done) begin
                  mem.req <= 1'b0;
                  state   <= H_BOOT_RD;
               end
            end
            H_BOOT_RD: begin
               if (mem_start) begin
                  mem.req <= 1'b1;
                  mem.we  <= 1'b0;
               end else if (mem_done) begin
                  mem.req    <= 1'b0;
                  reply_req  <= 1'b1;
                  reply_data <= mem.rdata; // word as stored
                  mem.addr   <= mem.addr + 1'b1;
                  boot_count <= boot_count - 1'b1;
                  if (boot_count > 1) begin
                     state <= H_BOOT_DATA;
                  end else begin
                     cpu_hold <= 1'b0; // program is in
                     state    <= H_IDLE;
                  end
               end
            end
            H_MEMRD_ADDR: begin
               if (take) begin
                  mem.addr <= host_data[`RAM_AW-1:0];
                  state    <= H_MEMRD_RD;
               end
            end
            H_MEMRD_RD: begin
               if (mem_start) begin
                  mem.req <= 1'b1;
                  mem.we  <= 1'b0;
               end else if (mem_done) begin
                  mem.req    <= 1'b0;
                  reply_req  <= 1'b1;
                  reply_data <= mem.rdata;
                  state      <= H_IDLE;
               end
            end
            H_SEND_DATA: begin
               if (take) begin
                  in_wr    <= !in_full; // word lost when full
                  in_wdata <= host_data;
                  state    <= H_IDLE;
               end
            end
            H_POLL: begin
               reply_req  <= 1'b1;
               reply_data <= out_empty ? `POLL_EMPTY : out_rdata;
               out_rd     <= !out_empty;
               state      <= H_IDLE;
            end
            default: state <= H_IDLE;
         endcase
      end
   end

   a_reply_stable: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      reply_req |=> !reply_req || $stable(reply_data));

endmodule

/* verilog/mem_arbiter.sv */
// fixed-priority ram arbiter for the host and cpu request channels
module mem_arbiter import soc_pkg::*; (
   input  logic       clk100mhz,
   input  logic       cpu_reset,
   mem_bus_if.arbiter host_mem,
   mem_bus_if.arbiter cpu_mem,
   output logic       ram_we,
   output ram_addr_t  ram_addr,
   output word_t      ram_wdata,
   input  word_t      ram_rdata
);

   typedef enum logic [1:0] {
      A_IDLE,
      A_GRANT, // ram sees the request this cycle
      A_RAM,   // registered read data is out
      A_HOLD   // ack held until the owner drops req
   } arb_state_t;

   arb_state_t state;
   logic       owner;     // 0 host, 1 cpu
   logic       ack_q;
   word_t      rdata_q;
   logic       owner_req;

   assign owner_req = owner ? cpu_mem.req : host_mem.req;

   // ram follows the owner and writes only in the grant cycle
   assign ram_addr  = owner ? cpu_mem.addr : host_mem.addr;
   assign ram_wdata = owner ? cpu_mem.wdata : host_mem.wdata;
   assign ram_we    = (state == A_GRANT) && (owner ? cpu_mem.we : host_mem.we);

   assign host_mem.ack   = ack_q && !owner;
   assign cpu_mem.ack    = ack_q && owner;
   assign host_mem.rdata = owner ? '0 : rdata_q;
   assign cpu_mem.rdata  = owner ? rdata_q : '0;

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         state <= A_IDLE;
         owner <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         case (state)
            A_IDLE: begin
               if (host_mem.req) begin // host first
                  owner <= 1'b0;
                  state <= A_GRANT;
               end else if (cpu_mem.req) begin
                  owner <= 1'b1;
                  state <= A_GRANT;
               end
            end
            A_GRANT: state <= A_RAM;
            A_RAM: begin
               ack_q <= 1'b1;
               state <= A_HOLD;
            end
            A_HOLD: begin
               if (!owner_req) begin
                  ack_q <= 1'b0;
                  state <= A_IDLE;
               end
            end
            default: state <= A_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk100mhz) begin
      if (state == A_RAM)
         rdata_q <= ram_rdata;
   end

   // the owner keeps req up until its ack
   a_req_held: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      (state == A_GRANT || state == A_RAM) |-> owner_req);

endmodule

/* verilog/mem_bus_if.sv */
// memory request channel from one master to the arbiter, with modports
interface mem_bus_if import soc_pkg::*; ();

   logic      req;
   logic      we;
   ram_addr_t addr;
   word_t     wdata;
   logic      ack;
   word_t     rdata; // valid while ack is high

   modport master (
      output req,
      output we,
      output addr,
      output wdata,
      input  ack,
      input  rdata
   );

   modport arbiter (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output ack,
      output rdata
   );

endinterface

/* verilog/small_soc_top.sv */
// top level with host controller, cpu decoder, arbiter, block ram and uart fifos
module small_soc_top import soc_pkg::*; (
   input  logic  clk100mhz,
   input  logic  cpu_reset,
   input  logic  host_req,
   input  word_t host_data,
   output logic  host_ack,
   output logic  reply_req,
   output word_t reply_data,
   input  logic  reply_ack,
   input  logic  cpu_rd,
   input  logic  cpu_wr,
   input  addr_t cpu_addr,
   input  word_t cpu_wdata,
   output word_t cpu_rdata,
   output logic  cpu_rdata_ready,
   output logic  cpu_wr_ack,
   output logic  cpu_hold
);

   mem_bus_if host_mem ();
   mem_bus_if cpu_mem ();

   logic      ram_we;
   ram_addr_t ram_addr;
   word_t     ram_wdata;
   word_t     ram_rdata;

   // host to cpu direction
   logic      in_wr;
   word_t     in_wdata;
   logic      in_rd;
   word_t     in_rdata;
   logic      in_full;
   logic      in_empty;

   // cpu to host direction
   logic      out_wr;
   word_t     out_wdata;
   logic      out_rd;
   word_t     out_rdata;
   logic      out_full;
   logic      out_empty;

   host_cmd_ctrl host_ctrl (
      .clk100mhz, .cpu_reset,
      .host_req, .host_data, .host_ack,
      .reply_req, .reply_data, .reply_ack,
      .mem(host_mem),
      .in_wr, .in_wdata, .in_full,
      .out_rd, .out_rdata, .out_empty,
      .cpu_hold
   );

   cpu_bus_decoder cpu_dec (
      .clk100mhz, .cpu_reset,
      .cpu_rd, .cpu_wr, .cpu_addr, .cpu_wdata,
      .cpu_rdata, .cpu_rdata_ready, .cpu_wr_ack,
      .cpu_hold,
      .mem(cpu_mem),
      .in_rd, .in_rdata, .in_empty,
      .out_wr, .out_wdata, .out_full
   );

   mem_arbiter arbiter (
      .clk100mhz, .cpu_reset,
      .host_mem, .cpu_mem,
      .ram_we, .ram_addr, .ram_wdata, .ram_rdata
   );

   block_ram ram (
      .clk100mhz,
      .we(ram_we),
      .addr(ram_addr),
      .wdata(ram_wdata),
      .rdata(ram_rdata)
   );

   word_fifo uart_in_fifo (
      .clk100mhz, .cpu_reset,
      .wr(in_wr), .wdata(in_wdata),
      .rd(in_rd), .rdata(in_rdata),
      .full(in_full), .empty(in_empty)
   );

   word_fifo uart_out_fifo (
      .clk100mhz, .cpu_reset,
      .wr(out_wr), .wdata(out_wdata),
      .rd(out_rd), .rdata(out_rdata),
      .full(out_full), .empty(out_empty)
   );

endmodule

/* verilog/soc_defs.svh */
// widths, address map, host command codes and fifo/ram depths
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define WORD_W       32
`define ADDR_W       32
`define RAM_AW       10
`define RAM_DEPTH    1024
`define FIFO_DEPTH   8

// cpu address map
`define MEM_BASE     32'h0002_0000
`define REG_UART_IN  32'h0001_0001 // pop inbound uart word
`define REG_IN_STAT  32'h0001_0002 // inbound not empty
`define REG_UART_OUT 32'h0001_0004 // push outbound uart word
`define REG_OUT_STAT 32'h0001_0005 // outbound not full

// host commands, code in the low half of the word
`define CMD_BOOT     16'd99
`define CMD_POLL     16'd1
`define CMD_SEND     16'd2
`define CMD_MEMRD    16'd8

`define POLL_EMPTY   32'hffff_ffff

`endif

/* verilog/soc_pkg.sv */
// word and address types, host controller and cpu decoder state enums
`include "soc_defs.svh"

package soc_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [`RAM_AW-1:0] ram_addr_t;

   typedef enum logic [3:0] {
      H_IDLE,        // waiting for a command word
      H_BOOT_COUNT,
      H_BOOT_DATA,
      H_BOOT_WR,
      H_BOOT_RD,     // read-back of the word just written
      H_MEMRD_ADDR,
      H_MEMRD_RD,
      H_SEND_DATA,
      H_POLL
   } host_state_t;

   typedef enum logic [1:0] {
      C_IDLE,
      C_MEM,         // memory access through the arbiter
      C_DONE         // reply held until the strobe falls
   } cpu_state_t;

endpackage

/* verilog/word_fifo.sv */
// first-word-fall-through word fifo with full and empty flags
`include "soc_defs.svh"

module word_fifo import soc_pkg::*; #(
   parameter int DEPTH = `FIFO_DEPTH
) (
   input  logic  clk100mhz,
   input  logic  cpu_reset,
   input  logic  wr,
   input  word_t wdata,
   input  logic  rd,
   output word_t rdata,
   output logic  full,
   output logic  empty
);

   localparam int PW = $clog2(DEPTH);

   word_t         mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic          push;
   logic          pop;

   assign push  = wr && !full;  // dropped when full
   assign pop   = rd && !empty;
   assign full  = count == (PW+1)'(DEPTH);
   assign empty = count == '0;
   assign rdata = mem[rd_ptr];  // head visible before the pop

   always_ff @(posedge clk100mhz) begin
      if (push)
         mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk100mhz) begin
      if (!cpu_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // writers check full before pushing
   a_no_wr_full: assert property (@(posedge clk100mhz) disable iff (!cpu_reset)
      full |-> !wr);

endmodule
